/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module decode_tb \
		-f compile.f -Mdir obj_dir -o decode_tb
	./obj_dir/decode_tb | tee /dev/stderr | grep -q '^NO ERRORS$$'

clean:
	rm -rf obj_dir

/* compile.f */
logic/decode_pkg.sv
logic/fetch_slot_split.sv
logic/instr_decoder.sv
logic/decode_stage.sv
logic/decode_top.sv
dv/decode_assertions.sv
dv/decode_tb.sv

/* dv/decode_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_assertions import decode_pkg::*; #(
  parameter int LANES = 2
) (
  input logic                  clock,
  input logic                  reset,
  input logic                  hold,
  input logic                  clear,
  input logic                  stall,
  input lane_out_t [LANES-1:0] lanes
);

  logic [LANES-1:0] valid_bits;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      valid_bits[i] = lanes[i].valid;
    end
  end

  clear_blocks_stall: assert property (@(posedge clock) clear |-> !stall)
    else $error("stall high while clear is high");

  hold_keeps_lanes: assert property (@(posedge clock) (reset && hold) |=> $stable(lanes))
    else $error("lanes changed under hold");

  reset_empties_lanes: assert property (@(posedge clock) !reset |=> valid_bits == '0)
    else $error("valid lane after reset");

endmodule

bind decode_stage decode_assertions #(
  .LANES(LANES)
) u_assertions (
  .clock(clock),
  .reset(reset),
  .hold(hold),
  .clear(clear),
  .stall(stall),
  .lanes(lanes)
);

`default_nettype wire

/* dv/decode_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_tb import decode_pkg::*; ();

  localparam int LANES = 2;
  localparam int CYCLE_LIMIT = 2000;

  logic                  clock;
  logic                  reset;
  logic [LANES-1:0]      bundle_valid;
  xlen_t [LANES-1:0]     bundle_pc;
  instr_t [LANES-1:0]    bundle_instr;
  exec_info_t            exec_info;
  logic                  hold;
  logic                  clear;
  lane_out_t [LANES-1:0] lanes;
  logic                  stall;

  int        seed = 99;
  int        errors = 0;
  int        cycles = 0;
  string     test_name = "reset";
  xlen_t     pc_base = 32'h0000_1000;
  logic      model_known = 1'b0;
  lane_out_t model [LANES];

  decode_top #(
    .LANES(LANES)
  ) dut0 (
    .clock(clock),
    .reset(reset),
    .bundle_valid(bundle_valid),
    .bundle_pc(bundle_pc),
    .bundle_instr(bundle_instr),
    .exec_info(exec_info),
    .hold(hold),
    .clear(clear),
    .lanes(lanes),
    .stall(stall)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("** Error %s %s: expected %h, actual %h", test_name, name, expected, actual);
    end
  endtask

  function automatic instr_t random_legal();
    logic [31:0] w1;
    logic [31:0] w2;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    int          pick;
    w1 = $random(seed);
    w2 = $random(seed);
    rd = w1[4:0];
    rs1 = w1[9:5];
    rs2 = w1[14:10];
    f3 = w1[17:15];
    imm = w2[11:0];
    pick = {28'd0, w2[19:16]} % 12;
    f7 = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, w2[20], 5'b0} : 7'b0;
    case (pick)
      0: return {imm, rs1, f3, rd, 7'b0110111};
      1: return {imm, rs1, f3, rd, 7'b0010111};
      2: return {imm, rs1, f3, rd, 7'b1101111};
      3: return {imm, rs1, 3'b000, rd, 7'b1100111};
      4: return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b1100011};
      5: return {imm, rs1, 3'b010, rd, 7'b0000011};
      6: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
      7: begin
        // Shift immediates need a clean upper field.
        if (f3 == 3'b001) return {7'b0, imm[4:0], rs1, f3, rd, 7'b0010011};
        if (f3 == 3'b101) return {1'b0, w2[20], 5'b0, imm[4:0], rs1, f3, rd, 7'b0010011};
        return {imm, rs1, f3, rd, 7'b0010011};
      end
      8: return {f7, rs2, rs1, f3, rd, 7'b0110011};
      9: return {imm, rs1, f3, rd, 7'b0001111};
      10: return 32'h0000_0073;
      default: return 32'h0010_0073;
    endcase
  endfunction

  function automatic alu_op_t alu_ref(input logic [2:0] f3, input logic bit30,
                                      input logic reg_form);
    case (f3)
      3'b000: return (reg_form && bit30) ? alu_sub : alu_add;
      3'b001: return alu_sll;
      3'b010: return alu_slt;
      3'b011: return alu_sltu;
      3'b100: return alu_xor;
      3'b101: return bit30 ? alu_sra : alu_srl;
      3'b110: return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic lane_out_t decode_ref(input logic valid, input xlen_t pc,
                                           input instr_t instr, output logic rd1,
                                           output logic rd2);
    lane_out_t  r;
    logic       legal;
    logic [2:0] f3;
    logic [6:0] f7;
    xlen_t      imm_i;
    r = '0;
    f3 = instr[14:12];
    f7 = instr[31:25];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    r.valid = valid;
    r.pc = pc;
    r.instr = instr;
    r.npc = pc + ((instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
    r.waddr = instr[11:7];
    r.raddr1 = instr[19:15];
    r.raddr2 = instr[24:20];
    r.alu_op = alu_add;
    r.op_class = class_illegal;
    r.ecause = cause_none;
    legal = 1'b1;
    rd1 = 1'b0;
    rd2 = 1'b0;
    case (instr[6:0])
      7'b0110111: begin
        r.op_class = class_lui;
        r.imm = {instr[31:12], 12'h0};
        r.wren = 1'b1;
      end
      7'b0010111: begin
        r.op_class = class_auipc;
        r.imm = {instr[31:12], 12'h0};
        r.wren = 1'b1;
      end
      7'b1101111: begin
        r.op_class = class_jal;
        r.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        r.wren = 1'b1;
      end
      7'b1100111: begin
        r.op_class = class_jalr;
        r.imm = imm_i;
        r.wren = 1'b1;
        rd1 = 1'b1;
      end
      7'b1100011: begin
        r.op_class = class_branch;
        r.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        rd1 = 1'b1;
        rd2 = 1'b1;
      end
      7'b0000011: begin
        r.op_class = class_load;
        r.imm = imm_i;
        r.wren = 1'b1;
        rd1 = 1'b1;
      end
      7'b0100011: begin
        r.op_class = class_store;
        r.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        rd1 = 1'b1;
        rd2 = 1'b1;
      end
      7'b0010011: begin
        r.op_class = class_alu;
        r.imm = imm_i;
        r.wren = 1'b1;
        rd1 = 1'b1;
        r.alu_op = alu_ref(f3, instr[30], 1'b0);
        if (f3 == 3'b001) legal = (f7 == 7'h00);
        if (f3 == 3'b101) legal = (f7 == 7'h00) || (f7 == 7'h20);
      end
      7'b0110011: begin
        r.op_class = class_alu;
        r.wren = 1'b1;
        rd1 = 1'b1;
        rd2 = 1'b1;
        r.alu_op = alu_ref(f3, instr[30], 1'b1);
        legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      end
      7'b0001111: r.op_class = class_fence;
      7'b1110011: begin
        r.op_class = class_system;
        r.imm = imm_i;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      r.op_class = class_illegal;
      r.wren = 1'b0;
      rd1 = 1'b0;
      rd2 = 1'b0;
    end
    // Illegal wins over ebreak, ebreak over ecall.
    if (valid) begin
      r.exception = 1'b1;
      if (!legal) r.ecause = cause_illegal_instruction;
      else if (instr[6:0] == 7'b1110011 && f3 == 3'b000 && instr[31:20] == 12'h001)
        r.ecause = cause_breakpoint;
      else if (instr[6:0] == 7'b1110011 && f3 == 3'b000 && instr[31:20] == 12'h000)
        r.ecause = cause_env_call_mach;
      else r.exception = 1'b0;
    end
    return r;
  endfunction

  task automatic compare_lane(input int i);
    string tag;
    tag = $sformatf("lane%0d", i);
    check_value({tag, " valid"}, 32'(model[i].valid), 32'(lanes[i].valid));
    check_value({tag, " exception"}, 32'(model[i].exception), 32'(lanes[i].exception));
    check_value({tag, " ecause"}, 32'(model[i].ecause), 32'(lanes[i].ecause));
    if (model[i].valid) begin
      check_value({tag, " pc"}, model[i].pc, lanes[i].pc);
      check_value({tag, " npc"}, model[i].npc, lanes[i].npc);
      check_value({tag, " instr"}, model[i].instr, lanes[i].instr);
      check_value({tag, " waddr"}, 32'(model[i].waddr), 32'(lanes[i].waddr));
      check_value({tag, " raddr1"}, 32'(model[i].raddr1), 32'(lanes[i].raddr1));
      check_value({tag, " raddr2"}, 32'(model[i].raddr2), 32'(lanes[i].raddr2));
      check_value({tag, " imm"}, model[i].imm, lanes[i].imm);
      check_value({tag, " wren"}, 32'(model[i].wren), 32'(lanes[i].wren));
      check_value({tag, " op_class"}, 32'(model[i].op_class), 32'(lanes[i].op_class));
      check_value({tag, " alu_op"}, 32'(model[i].alu_op), 32'(lanes[i].alu_op));
    end
  endtask

  // Inputs only move on the rising edge, so the falling edge sees them settled.
  always @(negedge clock) begin : compare_process
    lane_out_t expected [LANES];
    logic      rd1;
    logic      rd2;
    logic      hazard;
    hazard = 1'b0;
    for (int i = 0; i < LANES; i++) begin
      expected[i] = decode_ref(bundle_valid[i], bundle_pc[i], bundle_instr[i], rd1, rd2);
      if (bundle_valid[i] && exec_info.load && exec_info.waddr != 5'd0 &&
          ((rd1 && expected[i].raddr1 == exec_info.waddr) ||
           (rd2 && expected[i].raddr2 == exec_info.waddr))) begin
        hazard = 1'b1;
      end
      if (model_known) compare_lane(i);
    end
    check_value("stall", 32'(hazard && !clear), 32'(stall));
    for (int i = 0; i < LANES; i++) begin
      if (!reset || (!hold && (hazard || clear))) begin
        model[i].valid = 1'b0;
        model[i].exception = 1'b0;
        model[i].ecause = cause_none;
      end else if (!hold) begin
        model[i] = expected[i];
      end
    end
    if (!reset) model_known = 1'b1;
  end

  // Mode 0 is legal only, 1 adds illegal and trap words, 2 adds loads, 3 adds hold and clear.
  task automatic drive_cycle(input int mode);
    instr_t      ins [LANES];
    logic [31:0] w;
    @(posedge clock);
    w = $random(seed);
    for (int i = 0; i < LANES; i++) begin
      ins[i] = bundle_instr[i];
    end
    if (!stall && !hold) begin
      for (int i = 0; i < LANES; i++) begin
        if (mode != 0 && w[3*i +: 3] == 3'd0) ins[i] = $random(seed);
        else if (mode != 0 && w[3*i +: 3] == 3'd1) ins[i] = 32'h0000_0000;
        else ins[i] = random_legal();
        bundle_instr[i] <= ins[i];
        bundle_pc[i] <= pc_base + 32'(4 * i);
        bundle_valid[i] <= (w[9+2*i +: 2] != 2'b00);
      end
      pc_base = pc_base + 32'd8;
    end
    exec_info.load <= (mode >= 2) && w[16];
    case (w[18:17])
      2'd0: exec_info.waddr <= ins[0][19:15];
      2'd1: exec_info.waddr <= ins[1][24:20];
      2'd2: exec_info.waddr <= 5'd0;
      default: exec_info.waddr <= w[23:19];
    endcase
    clear <= (mode == 3) && (w[27:24] == 4'd0);
    hold <= (mode == 3) && (w[29:28] == 2'd0 || (hold && w[30]));
  endtask

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d errors", cycles, errors);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    reset = 1'b0;
    bundle_valid = '0;
    bundle_pc = '0;
    bundle_instr = '0;
    exec_info = '0;
    hold = 1'b0;
    clear = 1'b0;
    repeat (3) @(posedge clock);
    reset <= 1'b1;
    test_name = "legal decode";
    repeat (300) drive_cycle(0);
    test_name = "exceptions";
    repeat (250) drive_cycle(1);
    test_name = "load-use stall";
    repeat (300) drive_cycle(2);
    test_name = "hold and clear";
    repeat (350) drive_cycle(3);
    @(posedge clock);
    hold <= 1'b0;
    clear <= 1'b0;
    repeat (2) @(negedge clock);
    $display("Decode checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/decode_pkg.sv */
`default_nettype none

package decode_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;

  // RV32I major opcodes, low two bits included.
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_fence  = 7'b0001111;
  localparam logic [6:0] opc_system = 7'b1110011;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic [3:0] {
    class_alu,
    class_lui,
    class_auipc,
    class_jal,
    class_jalr,
    class_branch,
    class_load,
    class_store,
    class_system,
    class_fence,
    class_illegal
  } op_class_t;

  // Machine-mode trap cause codes.
  typedef enum logic [3:0] {
    cause_none                = 4'd0,
    cause_illegal_instruction = 4'd2,
    cause_breakpoint          = 4'd3,
    cause_env_call_mach       = 4'd11
  } ecause_t;

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    xlen_t     npc;
    instr_t    instr;
    reg_addr_t waddr;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
  } slot_t;

  typedef struct packed {
    xlen_t      imm;
    logic       wren;
    logic       rden1;
    logic       rden2;
    op_class_t  op_class;
    alu_op_t    alu_op;
    logic [2:0] funct3;
    logic       legal;
    logic       ecall;
    logic       ebreak;
  } decode_info_t;

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    xlen_t     npc;
    instr_t    instr;
    reg_addr_t waddr;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    xlen_t     imm;
    logic      wren;
    op_class_t op_class;
    alu_op_t   alu_op;
    logic      exception;
    ecause_t   ecause;
  } lane_out_t;

  typedef struct packed {
    logic      load;
    reg_addr_t waddr;
  } exec_info_t;

endpackage

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage import decode_pkg::*; #(
  parameter int LANES = 2
) (
  input  logic                      clock,
  input  logic                      reset,
  input  slot_t [LANES-1:0]         slots,
  input  decode_info_t [LANES-1:0]  infos,
  input  exec_info_t                exec_info,
  input  logic                      hold,
  input  logic                      clear,
  output lane_out_t [LANES-1:0]     lanes,
  output logic                      stall
);

  lane_out_t [LANES-1:0] lanes_next;
  logic                  hazard;

  always_comb begin
    hazard = 1'b0;
    for (int i = 0; i < LANES; i++) begin
      lanes_next[i].valid     = slots[i].valid;
      lanes_next[i].pc        = slots[i].pc;
      lanes_next[i].npc       = slots[i].npc;
      lanes_next[i].instr     = slots[i].instr;
      lanes_next[i].waddr     = slots[i].waddr;
      lanes_next[i].raddr1    = slots[i].raddr1;
      lanes_next[i].raddr2    = slots[i].raddr2;
      lanes_next[i].imm       = infos[i].imm;
      lanes_next[i].wren      = infos[i].wren;
      lanes_next[i].op_class  = infos[i].op_class;
      lanes_next[i].alu_op    = infos[i].alu_op;
      lanes_next[i].exception = 1'b0;
      lanes_next[i].ecause    = cause_none;

      // Illegal first, then ebreak, then ecall.
      if (slots[i].valid) begin
        if (!infos[i].legal) begin
          lanes_next[i].exception = 1'b1;
          lanes_next[i].ecause    = cause_illegal_instruction;
        end else if (infos[i].ebreak) begin
          lanes_next[i].exception = 1'b1;
          lanes_next[i].ecause    = cause_breakpoint;
        end else if (infos[i].ecall) begin
          lanes_next[i].exception = 1'b1;
          lanes_next[i].ecause    = cause_env_call_mach;
        end
      end

      // Load-use against the instruction in execute; x0 never waits.
      if (slots[i].valid && exec_info.load && exec_info.waddr != 5'd0) begin
        if ((infos[i].rden1 && slots[i].raddr1 == exec_info.waddr) ||
            (infos[i].rden2 && slots[i].raddr2 == exec_info.waddr)) begin
          hazard = 1'b1;
        end
      end
    end

    // Bubble on stall or flush.
    if (hazard || clear) begin
      for (int i = 0; i < LANES; i++) begin
        lanes_next[i].valid     = 1'b0;
        lanes_next[i].exception = 1'b0;
        lanes_next[i].ecause    = cause_none;
      end
    end
  end

  assign stall = hazard & ~clear;

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < LANES; i++) begin
        lanes[i].valid     <= 1'b0;
        lanes[i].exception <= 1'b0;
        lanes[i].ecause    <= cause_none;
      end
    end else if (!hold) begin
      lanes <= lanes_next;
    end
  end

endmodule

`default_nettype wire

/* logic/decode_top.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_top import decode_pkg::*; #(
  parameter int LANES = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [LANES-1:0]       bundle_valid,
  input  xlen_t [LANES-1:0]      bundle_pc,
  input  instr_t [LANES-1:0]     bundle_instr,
  input  exec_info_t             exec_info,
  input  logic                   hold,
  input  logic                   clear,
  output lane_out_t [LANES-1:0]  lanes,
  output logic                   stall
);

  slot_t [LANES-1:0]        slots;
  decode_info_t [LANES-1:0] infos;

  fetch_slot_split #(
    .LANES(LANES)
  ) u_split (
    .bundle_valid(bundle_valid),
    .bundle_pc(bundle_pc),
    .bundle_instr(bundle_instr),
    .slots(slots)
  );

  // One decoder per lane.
  for (genvar g = 0; g < LANES; g++) begin : gen_lane
    instr_decoder u_decoder (
      .instr(slots[g].instr),
      .info(infos[g])
    );
  end

  decode_stage #(
    .LANES(LANES)
  ) u_stage (
    .clock(clock),
    .reset(reset),
    .slots(slots),
    .infos(infos),
    .exec_info(exec_info),
    .hold(hold),
    .clear(clear),
    .lanes(lanes),
    .stall(stall)
  );

endmodule

`default_nettype wire

/* logic/fetch_slot_split.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_slot_split import decode_pkg::*; #(
  parameter int LANES = 2
) (
  input  logic [LANES-1:0]   bundle_valid,
  input  xlen_t [LANES-1:0]  bundle_pc,
  input  instr_t [LANES-1:0] bundle_instr,
  output slot_t [LANES-1:0]  slots
);

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      slots[i].valid = bundle_valid[i];
      slots[i].pc    = bundle_pc[i];
      slots[i].instr = bundle_instr[i];

      // Standard RV32 register field positions.
      slots[i].waddr  = bundle_instr[i][11:7];
      slots[i].raddr1 = bundle_instr[i][19:15];
      slots[i].raddr2 = bundle_instr[i][24:20];

      // A compressed encoding only changes the pc step here.
      if (bundle_instr[i][1:0] == 2'b11) begin
        slots[i].npc = bundle_pc[i] + 32'd4;
      end else begin
        slots[i].npc = bundle_pc[i] + 32'd2;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder import decode_pkg::*; (
  input  instr_t       instr,
  output decode_info_t info
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  alu_op_t    arith_op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Sign-extended immediates for every format.
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Sub only exists in OP; srai shares funct7 bit 5 with sra.
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = funct7[5] ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  end

  always_comb begin
    info          = '0;
    info.op_class = class_illegal;
    info.alu_op   = alu_add;
    info.funct3   = funct3;
    info.legal    = 1'b1;
    case (opcode)
      opc_lui: begin
        info.op_class = class_lui;
        info.imm      = imm_u;
        info.wren     = 1'b1;
      end
      opc_auipc: begin
        info.op_class = class_auipc;
        info.imm      = imm_u;
        info.wren     = 1'b1;
      end
      opc_jal: begin
        info.op_class = class_jal;
        info.imm      = imm_j;
        info.wren     = 1'b1;
      end
      opc_jalr: begin
        info.op_class = class_jalr;
        info.imm      = imm_i;
        info.wren     = 1'b1;
        info.rden1    = 1'b1;
      end
      opc_branch: begin
        info.op_class = class_branch;
        info.imm      = imm_b;
        info.rden1    = 1'b1;
        info.rden2    = 1'b1;
      end
      opc_load: begin
        info.op_class = class_load;
        info.imm      = imm_i;
        info.wren     = 1'b1;
        info.rden1    = 1'b1;
      end
      opc_store: begin
        info.op_class = class_store;
        info.imm      = imm_s;
        info.rden1    = 1'b1;
        info.rden2    = 1'b1;
      end
      opc_op_imm: begin
        info.op_class = class_alu;
        info.imm      = imm_i;
        info.wren     = 1'b1;
        info.rden1    = 1'b1;
        info.alu_op   = arith_op;
        if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
          info.legal = 1'b0;
        end
        if (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000) begin
          info.legal = 1'b0;
        end
      end
      opc_op: begin
        info.op_class = class_alu;
        info.wren     = 1'b1;
        info.rden1    = 1'b1;
        info.rden2    = 1'b1;
        info.alu_op   = arith_op;
        if (funct7 == 7'b0100000) begin
          info.legal = (funct3 == 3'b000) || (funct3 == 3'b101);
        end else if (funct7 != 7'b0000000) begin
          info.legal = 1'b0;
        end
      end
      opc_fence: begin
        info.op_class = class_fence;
      end
      opc_system: begin
        info.op_class = class_system;
        info.imm      = imm_i;
        info.ecall    = (funct3 == 3'b000) && (instr[31:20] == 12'h000);
        info.ebreak   = (funct3 == 3'b000) && (instr[31:20] == 12'h001);
      end
      default: begin
        info.legal = 1'b0;
      end
    endcase

    // Nothing of an illegal word may reach the register files.
    if (!info.legal) begin
      info.op_class = class_illegal;
      info.wren     = 1'b0;
      info.rden1    = 1'b0;
      info.rden2    = 1'b0;
    end
  end

endmodule

`default_nettype wire
